/* all.f */
+incdir+src
src/sd_cmd_pkg.sv
src/sd_clk_div.sv
src/sd_crc7.sv
src/sd_cmd_tx.sv
src/sd_rsp_rx.sv
src/sd_cmd_ctrl.sv
src/sd_cmd_top.sv
tb/tb_clk_gen.sv
tb/sd_cmd_props.sv
tb/sd_cmd_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the SD command engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module sd_cmd_tb -o sim_top
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

out=$(./obj_dir/sim_top +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1

/* src/sd_clk_div.sv */
// SD clock generator
// Makes sd_clk and one-cycle rising and falling enables
`timescale 1ns/1ps
`include "sd_cmd_settings.svh"

module sd_clk_div (
  input  logic clk_i,
  input  logic rst_i,
  output logic sd_clk_o,
  output logic clk_en_p_o,
  output logic clk_en_n_o
);

  localparam int CNT_W = $clog2(`SD_CLK_DIV);

  logic [CNT_W-1:0] cnt_q;
  logic             sd_clk_q;
  logic             en_p_q;
  logic             en_n_q;
  logic             wrap;

  assign wrap = (cnt_q == CNT_W'(`SD_CLK_DIV - 1));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q    <= '0;
      sd_clk_q <= 1'b0;
      en_p_q   <= 1'b0;
      en_n_q   <= 1'b0;
    end else begin
      // Enables line up with the cycle the clock changes level
      en_p_q <= wrap && !sd_clk_q;
      en_n_q <= wrap && sd_clk_q;
      if (wrap) begin
        cnt_q    <= '0;
        sd_clk_q <= ~sd_clk_q;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign sd_clk_o   = sd_clk_q;
  assign clk_en_p_o = en_p_q;
  assign clk_en_n_o = en_n_q;

endmodule

/* src/sd_cmd_ctrl.sv */
// Command state machine
// Request capture, wait and cooldown counter, response timeouts,
// index check and DAT0 busy wait
`timescale 1ns/1ps
`include "sd_cmd_settings.svh"

module sd_cmd_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       clk_en_p_i,
  input  logic                       clk_en_n_i,
  input  sd_cmd_pkg::sd_cmd_req_t    req_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  logic                       sd_cmd_i,
  output logic                       sd_cmd_o,
  output logic                       sd_cmd_oe_o,
  input  logic                       sd_dat0_i,
  output logic                       result_valid_o,
  output sd_cmd_pkg::sd_cmd_result_t result_o,
  output logic                       timeout_o,
  output logic                       cmd_done_o,
  output logic                       dat_busy_o
);

  localparam logic [`SD_CNT_W-1:0] N_CR_MIN = `SD_N_CR_MIN;
  localparam logic [`SD_CNT_W-1:0] N_CR_MAX = `SD_N_CR_MAX;
  localparam logic [`SD_CNT_W-1:0] N_ID     = `SD_N_ID;
  localparam logic [`SD_CNT_W-1:0] N_RC     = `SD_N_RC;
  localparam logic [`SD_CNT_W-1:0] N_CC     = `SD_N_CC;

  sd_cmd_pkg::cmd_state_e  state_q, state_d;
  sd_cmd_pkg::sd_cmd_req_t req_q;
  sd_cmd_pkg::rsp_data_t   rsp_data;
  logic [`SD_CNT_W-1:0]    cnt_q;
  logic req_fire;
  logic tx_done;
  logic receiving;
  logic rsp_valid;
  logic crc_ok;
  logic end_bit_err;
  logic cnt_clear;
  logic is_48;
  logic no_rsp;

  assign req_fire = (state_q == sd_cmd_pkg::ST_IDLE) && req_valid_i;
  assign is_48    = (req_q.rsp_type == sd_cmd_pkg::RSP_48) ||
                    (req_q.rsp_type == sd_cmd_pkg::RSP_48_BUSY);
  assign no_rsp   = (req_q.rsp_type == sd_cmd_pkg::RSP_NONE);

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      req_q <= req_i;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      sd_cmd_pkg::ST_IDLE:  if (req_fire) state_d = sd_cmd_pkg::ST_START;
      // Line the frame up with an SD clock edge
      sd_cmd_pkg::ST_START: if (clk_en_p_i) state_d = sd_cmd_pkg::ST_SEND;
      sd_cmd_pkg::ST_SEND: begin
        if (tx_done) begin
          state_d = no_rsp ? sd_cmd_pkg::ST_COOLDOWN : sd_cmd_pkg::ST_WAIT;
        end
      end
      sd_cmd_pkg::ST_WAIT: begin
        if (receiving) begin
          state_d = sd_cmd_pkg::ST_READ;
        end else if ((req_q.index == 6'd2 && cnt_q == N_ID) || cnt_q == N_CR_MAX) begin
          state_d = sd_cmd_pkg::ST_TIMEOUT;
        end
      end
      sd_cmd_pkg::ST_READ: begin
        if (rsp_valid) begin
          state_d = (req_q.rsp_type == sd_cmd_pkg::RSP_48_BUSY) ?
                    sd_cmd_pkg::ST_BUSY : sd_cmd_pkg::ST_COOLDOWN;
        end
      end
      sd_cmd_pkg::ST_BUSY: begin
        if (clk_en_p_i && sd_dat0_i) state_d = sd_cmd_pkg::ST_COOLDOWN;
      end
      sd_cmd_pkg::ST_COOLDOWN: begin
        if (cnt_q == (no_rsp ? N_CC : N_RC)) state_d = sd_cmd_pkg::ST_IDLE;
      end
      default: state_d = sd_cmd_pkg::ST_IDLE;
    endcase
  end

  // Counter restarts on entry to the wait and cooldown states
  assign cnt_clear = (state_d != state_q) && (state_d == sd_cmd_pkg::ST_WAIT ||
                                              state_d == sd_cmd_pkg::ST_COOLDOWN);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= sd_cmd_pkg::ST_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (cnt_clear) begin
        cnt_q <= '0;
      end else if (clk_en_p_i) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  sd_cmd_tx u_tx (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .clk_en_n_i (clk_en_n_i),
    .tx_start_i (state_q == sd_cmd_pkg::ST_START && clk_en_p_i),
    .index_i    (req_q.index),
    .arg_i      (req_q.arg),
    .cmd_o      (sd_cmd_o),
    .cmd_oe_o   (sd_cmd_oe_o),
    .tx_done_o  (tx_done)
  );

  sd_rsp_rx u_rx (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .clk_en_p_i    (clk_en_p_i),
    .listen_i      (state_q == sd_cmd_pkg::ST_WAIT && cnt_q == N_CR_MIN && clk_en_p_i),
    .abort_i       (state_q == sd_cmd_pkg::ST_TIMEOUT),
    .long_i        (req_q.rsp_type == sd_cmd_pkg::RSP_136),
    .cmd_i         (sd_cmd_i),
    .receiving_o   (receiving),
    .rsp_valid_o   (rsp_valid),
    .rsp_o         (rsp_data),
    .crc_ok_o      (crc_ok),
    .end_bit_err_o (end_bit_err)
  );

  assign req_ready_o    = (state_q == sd_cmd_pkg::ST_IDLE);
  assign cmd_done_o     = (state_q == sd_cmd_pkg::ST_SEND) && tx_done;
  assign timeout_o      = (state_q == sd_cmd_pkg::ST_TIMEOUT);
  assign result_valid_o = (state_q == sd_cmd_pkg::ST_READ) && rsp_valid;
  // DAT0 stays claimed for the whole busy-signalling command
  assign dat_busy_o     = (state_q != sd_cmd_pkg::ST_IDLE) &&
                          (req_q.rsp_type == sd_cmd_pkg::RSP_48_BUSY);

  assign result_o.rsp         = rsp_data;
  assign result_o.index_err   = is_48 && (rsp_data[37:32] != req_q.index);
  assign result_o.end_bit_err = end_bit_err;
  assign result_o.crc_err     = ~crc_ok;

endmodule

/* src/sd_cmd_pkg.sv */
// SD command engine types
// Index, argument and response typedefs, response type and FSM enums,
// request and result structs
package sd_cmd_pkg;

  typedef logic [5:0]   cmd_index_t;
  typedef logic [31:0]  cmd_arg_t;
  typedef logic [119:0] rsp_data_t;

  typedef enum logic [1:0] {
    RSP_NONE,
    RSP_48,
    RSP_48_BUSY,
    RSP_136
  } rsp_type_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_START,
    ST_SEND,
    ST_WAIT,
    ST_READ,
    ST_BUSY,
    ST_COOLDOWN,
    ST_TIMEOUT
  } cmd_state_e;

  // 40 bits in all
  typedef struct packed {
    cmd_index_t index;
    cmd_arg_t   arg;
    rsp_type_e  rsp_type;
  } sd_cmd_req_t;

  typedef struct packed {
    rsp_data_t rsp;
    logic      index_err;
    logic      end_bit_err;
    logic      crc_err;
  } sd_cmd_result_t;

endpackage

/* src/sd_cmd_settings.svh */
// SD command engine settings
// SD clock divider, wait counter width and spec timing gaps
`ifndef SD_CMD_SETTINGS_SVH
`define SD_CMD_SETTINGS_SVH

// Host clock cycles per half SD clock period (2 or more)
`define SD_CLK_DIV 2

// Width of the response wait and cooldown counter
`define SD_CNT_W 7

// Spec gaps in SD clock ticks
`define SD_N_CR_MIN 2
`define SD_N_CR_MAX 64
// CMD2 uses the short identification window
`define SD_N_ID 5
`define SD_N_RC 8
`define SD_N_CC 8

`endif

/* src/sd_cmd_top.sv */
// SD command engine top level
// SD clock divider and command controller
`timescale 1ns/1ps

module sd_cmd_top (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  sd_cmd_pkg::sd_cmd_req_t    req_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  output logic                       sd_clk_o,
  input  logic                       sd_cmd_i,
  output logic                       sd_cmd_o,
  output logic                       sd_cmd_oe_o,
  input  logic                       sd_dat0_i,
  output logic                       result_valid_o,
  output sd_cmd_pkg::sd_cmd_result_t result_o,
  output logic                       timeout_o,
  output logic                       cmd_done_o,
  output logic                       dat_busy_o
);

  logic clk_en_p;
  logic clk_en_n;

  sd_clk_div u_div (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .sd_clk_o   (sd_clk_o),
    .clk_en_p_o (clk_en_p),
    .clk_en_n_o (clk_en_n)
  );

  sd_cmd_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .clk_en_p_i     (clk_en_p),
    .clk_en_n_i     (clk_en_n),
    .req_i          (req_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .sd_cmd_i       (sd_cmd_i),
    .sd_cmd_o       (sd_cmd_o),
    .sd_cmd_oe_o    (sd_cmd_oe_o),
    .sd_dat0_i      (sd_dat0_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .timeout_o      (timeout_o),
    .cmd_done_o     (cmd_done_o),
    .dat_busy_o     (dat_busy_o)
  );

endmodule

/* src/sd_cmd_tx.sv */
// Command frame serialiser
// Start and transmit bits, index, argument, CRC7 and end bit
`timescale 1ns/1ps

module sd_cmd_tx (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   clk_en_n_i,
  input  logic                   tx_start_i,
  input  sd_cmd_pkg::cmd_index_t index_i,
  input  sd_cmd_pkg::cmd_arg_t   arg_i,
  output logic                   cmd_o,
  output logic                   cmd_oe_o,
  output logic                   tx_done_o
);

  logic [39:0] shift_q;
  logic [5:0]  cnt_q;
  logic [5:0]  crc_pos;
  logic [6:0]  crc;
  logic        sending_q;
  logic        cmd_q;
  logic        oe_q;
  logic        step;

  assign step    = sending_q && clk_en_n_i;
  // CRC goes out MSB first over bit slots 40..46
  assign crc_pos = 6'd46 - cnt_q;

  always_ff @(posedge clk_i) begin
    if (tx_start_i) begin
      shift_q <= {2'b01, index_i, arg_i};
    end else if (step && cnt_q < 6'd40) begin
      shift_q <= {shift_q[38:0], 1'b0};
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sending_q <= 1'b0;
      cnt_q     <= '0;
      cmd_q     <= 1'b1;
      oe_q      <= 1'b0;
    end else if (tx_start_i) begin
      sending_q <= 1'b1;
      cnt_q     <= '0;
    end else if (step) begin
      if (cnt_q == 6'd48) begin
        sending_q <= 1'b0;
        oe_q      <= 1'b0;
        cmd_q     <= 1'b1;
      end else begin
        oe_q  <= 1'b1;
        cnt_q <= cnt_q + 6'd1;
        if (cnt_q < 6'd40) begin
          cmd_q <= shift_q[39];
        end else if (cnt_q < 6'd47) begin
          cmd_q <= crc[crc_pos[2:0]];
        end else begin
          // End bit
          cmd_q <= 1'b1;
        end
      end
    end
  end

  sd_crc7 u_crc (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .clear_i (tx_start_i),
    .en_i    (step && cnt_q < 6'd40),
    .bit_i   (shift_q[39]),
    .crc_o   (crc)
  );

  assign cmd_o     = cmd_q;
  assign cmd_oe_o  = oe_q;
  assign tx_done_o = step && cnt_q == 6'd48;

endmodule

/* src/sd_crc7.sv */
// Bit-serial CRC7 on x^7 + x^3 + 1 taking bits MSB first
`timescale 1ns/1ps

module sd_crc7 (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       clear_i,
  input  logic       en_i,
  input  logic       bit_i,
  output logic [6:0] crc_o
);

  logic [6:0] crc_q;
  logic       fb;

  assign fb = bit_i ^ crc_q[6];

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      crc_q <= '0;
    end else if (en_i) begin
      crc_q <= {crc_q[5:3], crc_q[2] ^ fb, crc_q[1:0], fb};
    end
  end

  assign crc_o = crc_q;

endmodule

/* src/sd_rsp_rx.sv */
// Response deserialiser for 48- and 136-bit frames
// Start detection, content shift, CRC7 and end-bit checks
`timescale 1ns/1ps

module sd_rsp_rx (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  clk_en_p_i,
  input  logic                  listen_i,
  input  logic                  abort_i,
  input  logic                  long_i,
  input  logic                  cmd_i,
  output logic                  receiving_o,
  output logic                  rsp_valid_o,
  output sd_cmd_pkg::rsp_data_t rsp_o,
  output logic                  crc_ok_o,
  output logic                  end_bit_err_o
);

  sd_cmd_pkg::rsp_data_t rsp_q;
  logic [7:0] cnt_q;
  logic [7:0] hdr_len;
  logic [7:0] last_bit;
  logic [6:0] crc_rx_q;
  logic [6:0] crc_calc;
  logic       armed_q;
  logic       receiving_q;
  logic       valid_q;
  logic       crc_ok_q;
  logic       end_err_q;
  logic       sample;
  logic       start_det;
  logic       take_content;
  logic       take_crc;
  logic       take_end;

  // cnt_q counts the bits already taken including the start bit
  assign hdr_len      = long_i ? 8'd8 : 8'd1;
  assign last_bit     = long_i ? 8'd135 : 8'd47;
  assign sample       = receiving_q && clk_en_p_i;
  assign start_det    = armed_q && clk_en_p_i && !cmd_i;
  assign take_content = sample && cnt_q >= hdr_len && cnt_q < last_bit - 8'd7;
  assign take_crc     = sample && cnt_q >= last_bit - 8'd7 && cnt_q < last_bit;
  assign take_end     = sample && cnt_q == last_bit;

  always_ff @(posedge clk_i) begin
    if (rst_i || abort_i) begin
      armed_q     <= 1'b0;
      receiving_q <= 1'b0;
      valid_q     <= 1'b0;
      cnt_q       <= '0;
    end else begin
      valid_q <= take_end;
      if (listen_i) begin
        armed_q <= 1'b1;
      end
      if (start_det) begin
        armed_q     <= 1'b0;
        receiving_q <= 1'b1;
        cnt_q       <= 8'd1;
      end else if (sample) begin
        cnt_q <= cnt_q + 8'd1;
        if (take_end) begin
          receiving_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_det) begin
      rsp_q <= '0;
    end else if (take_content) begin
      rsp_q <= {rsp_q[118:0], cmd_i};
    end
    if (take_crc) begin
      crc_rx_q <= {crc_rx_q[5:0], cmd_i};
    end
    if (take_end) begin
      end_err_q <= ~cmd_i;
      crc_ok_q  <= (crc_rx_q == crc_calc);
    end
  end

  // A zero start bit leaves a cleared CRC at zero, so it needs no feeding
  sd_crc7 u_crc (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .clear_i (start_det),
    .en_i    (take_content),
    .bit_i   (cmd_i),
    .crc_o   (crc_calc)
  );

  assign receiving_o   = receiving_q;
  assign rsp_valid_o   = valid_q;
  assign rsp_o         = rsp_q;
  assign crc_ok_o      = crc_ok_q;
  assign end_bit_err_o = end_err_q;

endmodule

/* tb/sd_cmd_props.sv */
// Protocol assertions for the SD command engine
// Bound into sd_cmd_top
`timescale 1ns/1ps

module sd_cmd_props (
  input logic                   clk_i,
  input logic                   rst_i,
  input logic                   req_ready_i,
  input logic                   cmd_oe_i,
  input logic                   result_valid_i,
  input logic                   timeout_i,
  input logic                   cmd_done_i,
  input logic                   dat_busy_i,
  input sd_cmd_pkg::cmd_state_e state_i
);

  int fail_cnt = 0;

  // No new request while the engine drives CMD
  a_ready_oe: assert property (@(posedge clk_i) disable iff (rst_i) cmd_oe_i |-> !req_ready_i)
    else begin
      $error("req_ready_o high while sd_cmd_oe_o drives the line");
      fail_cnt++;
    end

  a_res_to: assert property (@(posedge clk_i) disable iff (rst_i)
                             !(result_valid_i && timeout_i))
    else begin
      $error("result_valid_o and timeout_o high in the same cycle");
      fail_cnt++;
    end

  a_done_pulse: assert property (@(posedge clk_i) disable iff (rst_i) cmd_done_i |=> !cmd_done_i)
    else begin
      $error("cmd_done_o held longer than one cycle");
      fail_cnt++;
    end

  a_res_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
                                result_valid_i |=> !result_valid_i)
    else begin
      $error("result_valid_o held longer than one cycle");
      fail_cnt++;
    end

  a_to_pulse: assert property (@(posedge clk_i) disable iff (rst_i) timeout_i |=> !timeout_i)
    else begin
      $error("timeout_o held longer than one cycle");
      fail_cnt++;
    end

  // Busy state always claims DAT0
  a_busy: assert property (@(posedge clk_i) disable iff (rst_i)
                           state_i == sd_cmd_pkg::ST_BUSY |-> dat_busy_i)
    else begin
      $error("dat_busy_o low while the controller waits on DAT0");
      fail_cnt++;
    end

endmodule

bind sd_cmd_top sd_cmd_props u_props (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .req_ready_i    (req_ready_o),
  .cmd_oe_i       (sd_cmd_oe_o),
  .result_valid_i (result_valid_o),
  .timeout_i      (timeout_o),
  .cmd_done_i     (cmd_done_o),
  .dat_busy_i     (dat_busy_o),
  .state_i        (u_ctrl.state_q)
);

/* tb/sd_cmd_tb.sv */
// SD command engine testbench
// Card model, LCG stimulus, directed tests, watchdog and reporting
`timescale 1ns/1ps
`include "sd_cmd_settings.svh"

module sd_cmd_tb;

  localparam int     TICK_NS     = 2 * `SD_CLK_DIV * 100;
  // Six tests of 300 SD ticks with a factor of two margin
  localparam longint WATCHDOG_NS = 64'd6 * 300 * TICK_NS * 2;

  logic clk;
  logic rst;
  sd_cmd_pkg::sd_cmd_req_t    req;
  logic req_valid;
  logic req_ready;
  logic sd_clk;
  logic card_cmd;
  logic host_cmd;
  logic host_cmd_oe;
  logic dat0;
  logic result_valid;
  sd_cmd_pkg::sd_cmd_result_t result;
  logic timeout;
  logic cmd_done;
  logic dat_busy;

  logic [31:0] lcg_state;
  int  err_cnt = 0;
  int  check_cnt = 0;
  int  test_num = 0;
  int  test_err_base = 0;
  int  res_cnt = 0;
  int  to_cnt = 0;
  int  done_cnt = 0;
  int  res_base;
  int  to_base;
  int  done_base;
  time to_time;
  sd_cmd_pkg::sd_cmd_result_t last_res;

  tb_clk_gen u_clk (.clk_o(clk));

  sd_cmd_top u_dut (
    .clk_i          (clk),
    .rst_i          (rst),
    .req_i          (req),
    .req_valid_i    (req_valid),
    .req_ready_o    (req_ready),
    .sd_clk_o       (sd_clk),
    .sd_cmd_i       (card_cmd),
    .sd_cmd_o       (host_cmd),
    .sd_cmd_oe_o    (host_cmd_oe),
    .sd_dat0_i      (dat0),
    .result_valid_o (result_valid),
    .result_o       (result),
    .timeout_o      (timeout),
    .cmd_done_o     (cmd_done),
    .dat_busy_o     (dat_busy)
  );

  // Pulse counters sampled mid-cycle
  always @(negedge clk) begin
    if (result_valid) begin
      res_cnt  = res_cnt + 1;
      last_res = result;
    end
    if (timeout) begin
      to_cnt  = to_cnt + 1;
      to_time = $time;
    end
    if (cmd_done) begin
      done_cnt = done_cnt + 1;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("TB FAILED");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // CRC7 on x^7 + x^3 + 1 from a zero register taking bits MSB first
  function automatic logic [6:0] crc7_of(input logic [135:0] data, input int nbits);
    logic [6:0] c;
    logic       fb;
    c = '0;
    for (int i = nbits - 1; i >= 0; i--) begin
      fb = data[i] ^ c[6];
      c  = {c[5:0], 1'b0};
      if (fb) begin
        c = c ^ 7'h09;
      end
    end
    return c;
  endfunction

  function automatic logic [47:0] cmd_frame(input logic [5:0] idx, input logic [31:0] arg);
    logic [39:0] head;
    head = {2'b01, idx, arg};
    return {head, crc7_of(head, 40), 1'b1};
  endfunction

  function automatic logic [47:0] rsp48_frame(input logic [5:0] idx, input logic [31:0] body,
                                              input logic flip_crc, input logic bad_end);
    logic [39:0] head;
    logic [6:0]  crc;
    head = {2'b00, idx, body};
    crc  = crc7_of(head, 40) ^ {6'b0, flip_crc};
    return {head, crc, ~bad_end};
  endfunction

  task automatic check_hex(input string name, input logic [135:0] exp, input logic [135:0] act);
    check_cnt++;
    assert (exp === act) else begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    check_cnt++;
    assert (cond) else begin
      $display("%s", what);
      err_cnt++;
    end
  endtask

  task automatic issue(input logic [5:0] idx, input logic [31:0] arg,
                       input sd_cmd_pkg::rsp_type_e rt);
    @(negedge clk);
    req.index    = idx;
    req.arg      = arg;
    req.rsp_type = rt;
    req_valid    = 1'b1;
    while (!req_ready) @(negedge clk);
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  // Card side samples CMD on rising SD clock
  task automatic capture_frame(output logic [47:0] f);
    do begin
      @(posedge sd_clk);
    end while (!host_cmd_oe);
    f[47] = host_cmd;
    for (int i = 46; i >= 0; i--) begin
      @(posedge sd_clk);
      f[i] = host_cmd;
    end
  endtask

  // Starts after 3 SD ticks and changes bits on the falling SD clock
  task automatic drive_response(input logic [135:0] f, input int nbits, input logic busy);
    repeat (3) @(posedge sd_clk);
    for (int i = nbits - 1; i >= 0; i--) begin
      @(negedge sd_clk);
      @(negedge clk);
      card_cmd = f[i];
      if (busy && i == nbits - 1) begin
        dat0 = 1'b0;
      end
    end
    @(negedge sd_clk);
    @(negedge clk);
    card_cmd = 1'b1;
  endtask

  task automatic hold_busy(input int ticks);
    repeat (ticks) begin
      @(posedge sd_clk);
      @(negedge clk);
      check_true(dat_busy && !req_ready, "busy wait: engine left busy while DAT0 was low");
    end
    dat0 = 1'b1;
  endtask

  task automatic wait_ready();
    while (!req_ready) @(negedge clk);
  endtask

  task automatic snap_counts();
    done_base = done_cnt;
    res_base  = res_cnt;
    to_base   = to_cnt;
  endtask

  task automatic check_counts(input int d_done, input int d_res, input int d_to);
    check_hex("cmd_done_o pulses", done_base + d_done, done_cnt);
    check_hex("result_valid_o pulses", res_base + d_res, res_cnt);
    check_hex("timeout_o pulses", to_base + d_to, to_cnt);
  endtask

  task automatic check_result(input logic [119:0] rsp, input logic idx_e,
                              input logic end_e, input logic crc_e);
    check_hex("result_o.rsp", rsp, last_res.rsp);
    check_hex("result_o.index_err", idx_e, last_res.index_err);
    check_hex("result_o.end_bit_err", end_e, last_res.end_bit_err);
    check_hex("result_o.crc_err", crc_e, last_res.crc_err);
  endtask

  task automatic end_test(input string name);
    test_num++;
    $display("test %0d %s: %0d errors", test_num, name, err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  initial begin
    logic [47:0]  f;
    logic [47:0]  rf;
    logic [135:0] lf;
    logic [127:0] wide;
    logic [31:0]  arg;
    time          t0;
    time          lat_id;
    time          lat_cr;
    int           k;

    lcg_state = 32'h873e_769f;
    rst       = 1'b1;
    req       = '0;
    req_valid = 1'b0;
    card_cmd  = 1'b1;
    dat0      = 1'b1;
    repeat (5) @(negedge clk);
    rst = 1'b0;

    arg = next_rand();
    snap_counts();
    issue(6'd0, arg, sd_cmd_pkg::RSP_NONE);
    capture_frame(f);
    check_hex("sd_cmd_o frame", cmd_frame(6'd0, arg), f);
    wait_ready();
    check_counts(1, 0, 0);
    end_test("no response");

    arg = next_rand();
    rf  = rsp48_frame(6'd17, next_rand(), 1'b0, 1'b0);
    snap_counts();
    issue(6'd17, arg, sd_cmd_pkg::RSP_48);
    capture_frame(f);
    check_hex("sd_cmd_o frame", cmd_frame(6'd17, arg), f);
    drive_response(rf, 48, 1'b0);
    wait_ready();
    check_counts(1, 1, 0);
    check_result(rf[47:8], 1'b0, 1'b0, 1'b0);
    end_test("short response");

    // Case 0 flips a CRC bit, case 1 echoes a wrong index, case 2 clears the end bit
    for (k = 0; k < 3; k++) begin
      arg = next_rand();
      rf  = rsp48_frame((k == 1) ? 6'd9 : 6'd13, next_rand(), k == 0, k == 2);
      snap_counts();
      issue(6'd13, arg, sd_cmd_pkg::RSP_48);
      capture_frame(f);
      check_hex("sd_cmd_o frame", cmd_frame(6'd13, arg), f);
      drive_response(rf, 48, 1'b0);
      wait_ready();
      check_counts(1, 1, 0);
      check_result(rf[47:8], k == 1, k == 2, k == 0);
    end
    end_test("corrupt responses");

    arg  = next_rand();
    wide = {next_rand(), next_rand(), next_rand(), next_rand()};
    lf   = {8'h3f, wide[119:0], crc7_of(wide[119:0], 120), 1'b1};
    snap_counts();
    issue(6'd2, arg, sd_cmd_pkg::RSP_136);
    capture_frame(f);
    check_hex("sd_cmd_o frame", cmd_frame(6'd2, arg), f);
    drive_response(lf, 136, 1'b0);
    wait_ready();
    check_counts(1, 1, 0);
    check_result(wide[119:0], 1'b0, 1'b0, 1'b0);
    end_test("long response");

    // Silent card with latency measured from the end bit
    arg = next_rand();
    snap_counts();
    issue(6'd2, arg, sd_cmd_pkg::RSP_136);
    capture_frame(f);
    t0 = $time;
    wait_ready();
    lat_id = to_time - t0;
    check_counts(1, 0, 1);
    snap_counts();
    issue(6'd13, arg, sd_cmd_pkg::RSP_48);
    capture_frame(f);
    t0 = $time;
    wait_ready();
    lat_cr = to_time - t0;
    check_counts(1, 0, 1);
    check_true(lat_id < lat_cr, "timeout: CMD2 did not time out before the general window");
    check_true(lat_id <= (`SD_N_ID + 1) * TICK_NS, "timeout: CMD2 window too long");
    check_true(lat_cr >= `SD_N_CR_MAX * TICK_NS, "timeout: general window too short");
    end_test("silent card");

    arg = next_rand();
    rf  = rsp48_frame(6'd7, next_rand(), 1'b0, 1'b0);
    snap_counts();
    issue(6'd7, arg, sd_cmd_pkg::RSP_48_BUSY);
    capture_frame(f);
    check_hex("sd_cmd_o frame", cmd_frame(6'd7, arg), f);
    drive_response(rf, 48, 1'b1);
    hold_busy(20);
    wait_ready();
    check_counts(1, 1, 0);
    check_result(rf[47:8], 1'b0, 1'b0, 1'b0);
    check_true(!dat_busy, "busy wait: dat_busy_o still high after return to idle");
    // Engine takes a new request after the busy wait
    arg = next_rand();
    snap_counts();
    issue(6'd55, arg, sd_cmd_pkg::RSP_NONE);
    capture_frame(f);
    check_hex("sd_cmd_o frame", cmd_frame(6'd55, arg), f);
    wait_ready();
    check_counts(1, 0, 0);
    end_test("busy wait");

    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             test_num, check_cnt, err_cnt, u_dut.u_props.fail_cnt);
    if (err_cnt == 0 && u_dut.u_props.fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* tb/tb_clk_gen.sv */
// Free-running testbench clock with a 100 ns period
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

endmodule
